//--- tb.f
+incdir+.
layer_pkg.sv
layer_regs.sv
fetch_addr_gen.sv
line_fetch_ctrl.sv
pixel_renderer.sv
layer_renderer.sv
layer_properties.sv
tb_layer_renderer.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_layer_renderer -f tb.f
out=$(./obj_dir/Vtb_layer_renderer +verilator+error+limit+1000000 || true)
echo "$out"
echo "$out" | grep -qx "test passed"

//--- tb_layer_renderer.sv
`include "layer_consts.svh"

module tb_layer_renderer;

    timeunit 1ns;
    timeprecision 1ps;

    logic        clk;
    logic        rst;
    logic        start_of_screen;
    logic        start_of_line;
    logic [3:0]  regs_addr;
    logic [7:0]  regs_wrdata;
    logic        regs_write;
    logic [7:0]  regs_rddata;
    logic [17:0] bus_addr;
    logic        bus_strobe;
    logic        bus_ack;
    logic [31:0] bus_rddata;
    logic [9:0]  linebuf_wridx;
    logic [7:0]  linebuf_wrdata;
    logic        linebuf_wren;

    logic [31:0] lfsr = 32'h88e7;
    int          cycles = 0;
    int          wr_total = 0;   // Line buffer writes so far
    int          wr_target = 0;

    layer_renderer DUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= 20000) begin
            $display("timeout: render did not finish within 20000 cycles");
            $display("test failed");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (linebuf_wren) begin
            wr_total++;
        end
    end

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] mem_word(input logic [17:0] a);
        logic [15:0] w;
        w = a[17:2];
        return {({w[7:0], w[15:8]} ^ 16'ha5c3), (w + 16'h3c5a)};
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Bus memory model, ack after 1 to 3 cycles
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic [17:0] addr;
        logic [1:0]  bits;
        int          delay;
        forever begin
            @(negedge clk);
            if (bus_strobe) begin
                addr = bus_addr;
                lfsr = lfsr_step(lfsr);
                bits[0] = lfsr[0];
                lfsr = lfsr_step(lfsr);
                bits[1] = lfsr[0];
                delay = (bits % 3) + 1;
                @(posedge clk);
                repeat (delay - 1) @(posedge clk);
                #2;
                bus_ack    = 1'b1;
                bus_rddata = mem_word(addr);
                @(posedge clk);
                #2;
                bus_ack = 1'b0;
            end
        end
    end

    task automatic write_reg(input logic [3:0] a, input logic [7:0] d);
        @(posedge clk);
        #2;
        regs_addr   = a;
        regs_wrdata = d;
        regs_write  = 1'b1;
        @(posedge clk);
        #2;
        regs_write = 1'b0;
    endtask

    // Readback is checked by the bound assertions
    task automatic sweep_regs();
        for (int a = 0; a < 8; a++) begin
            @(posedge clk);
            #2;
            regs_addr = 4'(a);
        end
        @(posedge clk);
    endtask

    task automatic render_line(input logic new_screen);
        wr_target += `LAYER_LINE_PIXELS;
        @(posedge clk);
        #2;
        start_of_screen = new_screen;
        start_of_line   = 1'b1;
        @(posedge clk);
        #2;
        start_of_screen = 1'b0;
        start_of_line   = 1'b0;
        while (wr_total < wr_target) @(posedge clk);
        repeat (3) @(posedge clk);  // Let the controller settle to idle
    endtask

    initial begin
        rst             = 1'b1;
        start_of_screen = 1'b0;
        start_of_line   = 1'b0;
        regs_addr       = 4'd0;
        regs_wrdata     = 8'd0;
        regs_write      = 1'b0;
        bus_ack         = 1'b0;
        bus_rddata      = 32'd0;
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
        repeat (4) @(posedge clk);

        sweep_regs();                      // Reset values
        write_reg(`LAYER_REG_CTRL, 8'h01);
        sweep_regs();
        write_reg(`LAYER_REG_CTRL, 8'h00);
        write_reg(`LAYER_REG_MAP_LO, 8'h00);
        write_reg(`LAYER_REG_MAP_HI, 8'h01);
        write_reg(`LAYER_REG_TILE_LO, 8'h00);
        write_reg(`LAYER_REG_TILE_HI, 8'h40);
        write_reg(4'd1, 8'hff);            // Unused, reads 0
        write_reg(4'd7, 8'h55);
        sweep_regs();

        render_line(1'b1);                 // 4bpp lines 0 and 1
        render_line(1'b0);

        write_reg(`LAYER_REG_CTRL, 8'h01);
        write_reg(`LAYER_REG_MAP_HI, 8'h08);
        write_reg(`LAYER_REG_TILE_HI, 8'hc0);
        sweep_regs();

        render_line(1'b1);                 // 8bpp lines 0 and 1
        render_line(1'b0);
        repeat (4) @(posedge clk);

        $display("errors: value %0d, protocol %0d",
                 DUT.u_props.err_value, DUT.u_props.err_proto);
        if (DUT.u_props.err_value == 0 && DUT.u_props.err_proto == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- layer_properties.sv
`include "layer_consts.svh"

module layer_properties import layer_pkg::*; (
    input logic        clk,
    input logic        rst,
    input logic        start_of_screen,
    input logic        start_of_line,
    input logic [3:0]  regs_addr,
    input logic [7:0]  regs_wrdata,
    input logic        regs_write,
    input logic [7:0]  regs_rddata,
    input logic [17:0] bus_addr,
    input logic        bus_strobe,
    input logic        bus_ack,
    input logic [9:0]  linebuf_wridx,
    input logic [7:0]  linebuf_wrdata,
    input logic        linebuf_wren,
    input logic [2:0]  ctrl_state
);

    timeunit 1ns;
    timeprecision 1ps;

    int          err_value = 0;
    int          err_proto = 0;
    logic        seen_line;
    logic [11:0] cur_line;
    logic [11:0] next_line;
    logic [10:0] wr_count;   // Pixels written on this line
    logic        depth_sh;
    logic [15:0] map_sh;
    logic [15:0] tile_sh;
    logic [7:0]  exp_rd;
    logic [7:0]  exp_pix;
    logic [15:0] map_ofs;

    // Memory contents as the bus model serves them
    function automatic logic [31:0] mem_word(input logic [17:0] a);
        logic [15:0] w;
        w = a[17:2];
        return {({w[7:0], w[15:8]} ^ 16'ha5c3), (w + 16'h3c5a)};
    endfunction

    function automatic logic [7:0] pixel_of(input logic [9:0] x, input logic [11:0] v);
        logic [6:0]  col;
        logic [9:0]  midx;
        logic [15:0] mw;
        logic [31:0] md;
        logic [15:0] ent;
        logic [15:0] tw;
        logic [31:0] td;
        logic [7:0]  b;
        logic [3:0]  nib;
        col  = x[9:3];
        midx = {v[7:3], col[4:0]};
        mw   = map_sh + {7'b0, midx[9:1]};
        md   = mem_word({mw, 2'b00});
        ent  = col[0] ? md[31:16] : md[15:0];
        if (depth_sh) begin
            tw = tile_sh + {2'b0, ent[9:0], v[2:0], x[2]};  // Two words per tile row
            td = mem_word({tw, 2'b00});
            return td[{x[1:0], 3'b000} +: 8];
        end
        tw  = tile_sh + {3'b0, ent[9:0], v[2:0]};
        td  = mem_word({tw, 2'b00});
        b   = td[{x[2:1], 3'b000} +: 8];
        nib = x[0] ? b[3:0] : b[7:4];
        return (nib == 4'd0) ? 8'h00 : {ent[15:12], nib};
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            seen_line <= 1'b0;
            cur_line  <= 12'd0;
            next_line <= 12'd0;
            wr_count  <= 11'd0;
            depth_sh  <= 1'b0;
            map_sh    <= `LAYER_MAP_RESET;
            tile_sh   <= `LAYER_TILE_RESET;
        end else begin
            if (regs_write) begin
                case (regs_addr)
                    `LAYER_REG_CTRL:    depth_sh      <= regs_wrdata[0];
                    `LAYER_REG_MAP_LO:  map_sh[7:0]   <= regs_wrdata;
                    `LAYER_REG_MAP_HI:  map_sh[15:8]  <= regs_wrdata;
                    `LAYER_REG_TILE_LO: tile_sh[7:0]  <= regs_wrdata;
                    `LAYER_REG_TILE_HI: tile_sh[15:8] <= regs_wrdata;
                    default: begin
                    end
                endcase
            end
            if (start_of_line) begin
                seen_line <= 1'b1;
                cur_line  <= next_line;
                next_line <= next_line + 12'd1;
                wr_count  <= 11'd0;
            end else if (linebuf_wren) begin
                wr_count <= wr_count + 11'd1;
            end
            if (start_of_screen) begin  // First line of a screen is 0
                cur_line  <= 12'd0;
                next_line <= start_of_line ? 12'd1 : 12'd0;
            end
        end
    end

    always_comb begin
        case (regs_addr)
            `LAYER_REG_CTRL:    exp_rd = {7'b0, depth_sh};
            `LAYER_REG_MAP_LO:  exp_rd = map_sh[7:0];
            `LAYER_REG_MAP_HI:  exp_rd = map_sh[15:8];
            `LAYER_REG_TILE_LO: exp_rd = tile_sh[7:0];
            `LAYER_REG_TILE_HI: exp_rd = tile_sh[15:8];
            default:            exp_rd = 8'h00;
        endcase
    end

    assign exp_pix = pixel_of(wr_count[9:0], cur_line);
    assign map_ofs = bus_addr[17:2] - map_sh;

    ////////////////////////////////////////////////////////////////////////////
    // Bus and register checks
    ////////////////////////////////////////////////////////////////////////////

    a_quiet: assert property (@(posedge clk) disable iff (rst)
        !seen_line |-> !bus_strobe && !linebuf_wren)
        else begin
            err_proto++;
            $error("bus strobe or line buffer write before the first start_of_line");
        end

    a_regs: assert property (@(posedge clk) disable iff (rst) regs_rddata == exp_rd)
        else begin
            err_value++;
            $error("ERR %0t regs_rddata expected %h got %h",
                   $time, $sampled(exp_rd), $sampled(regs_rddata));
        end

    a_align: assert property (@(posedge clk) disable iff (rst)
        bus_strobe |-> bus_addr[1:0] == 2'b00)
        else begin
            err_proto++;
            $error("bus address not word aligned");
        end

    // Held through the ack cycle too
    a_stable: assert property (@(posedge clk) disable iff (rst)
        (bus_strobe || bus_ack) && $past(bus_strobe) |-> $stable(bus_addr))
        else begin
            err_proto++;
            $error("bus address changed between the strobe and the ack");
        end

    a_map: assert property (@(posedge clk) disable iff (rst)
        bus_strobe && ctrl_state == 3'd2 |-> map_ofs < 16'd512)  // Map wait state
        else begin
            err_proto++;
            $error("map fetch outside the map region");
        end

    ////////////////////////////////////////////////////////////////////////////
    // Line buffer checks
    ////////////////////////////////////////////////////////////////////////////

    a_index: assert property (@(posedge clk) disable iff (rst)
        linebuf_wren |-> linebuf_wridx == wr_count[9:0] && wr_count < 11'd640)
        else begin
            err_value++;
            $error("ERR %0t linebuf_wridx expected %0d got %0d",
                   $time, $sampled(wr_count), $sampled(linebuf_wridx));
        end

    // No gap until the last pixel of a word
    a_burst: assert property (@(posedge clk) disable iff (rst)
        linebuf_wren && (depth_sh ? wr_count[1:0] != 2'd3 : wr_count[2:0] != 3'd7)
        |=> linebuf_wren)
        else begin
            err_proto++;
            $error("line buffer writes paused inside a tile word");
        end

    a_pixel: assert property (@(posedge clk) disable iff (rst)
        linebuf_wren |-> linebuf_wrdata == exp_pix)
        else begin
            err_value++;
            $error("ERR %0t linebuf_wrdata expected %h got %h",
                   $time, $sampled(exp_pix), $sampled(linebuf_wrdata));
        end

    a_end: assert property (@(posedge clk) disable iff (rst)
        wr_count == 11'd640 |-> !bus_strobe && ctrl_state == 3'd0)
        else begin
            err_proto++;
            $error("controller not idle after the line was written");
        end

endmodule

bind layer_renderer layer_properties u_props (
    .clk, .rst, .start_of_screen, .start_of_line,
    .regs_addr, .regs_wrdata, .regs_write, .regs_rddata,
    .bus_addr, .bus_strobe, .bus_ack,
    .linebuf_wridx, .linebuf_wrdata, .linebuf_wren,
    .ctrl_state(u_ctrl.state)
);

//--- layer_renderer.sv
module layer_renderer import layer_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        start_of_screen,
    input  logic        start_of_line,
    input  logic [3:0]  regs_addr,
    input  logic [7:0]  regs_wrdata,
    input  logic        regs_write,
    output logic [7:0]  regs_rddata,
    output logic [17:0] bus_addr,
    output logic        bus_strobe,
    input  logic        bus_ack,
    input  logic [31:0] bus_rddata,
    output logic [9:0]  linebuf_wridx,
    output logic [7:0]  linebuf_wrdata,
    output logic        linebuf_wren
);

    layer_cfg_t   cfg;
    logic [11:0]  line_idx;
    logic [7:0]   tile_col;
    map_entry_t   cur_entry;
    logic         word_sel;
    logic [17:0]  map_addr;
    logic [17:0]  tile_addr;
    logic         render_start;
    render_word_t rword;
    logic         render_busy;
    logic         line_done;

    layer_regs u_regs (
        .clk, .rst, .regs_addr, .regs_wrdata, .regs_write, .regs_rddata, .cfg
    );

    fetch_addr_gen u_addr (
        .cfg, .line_idx, .tile_col, .cur_entry, .word_sel, .map_addr, .tile_addr
    );

    line_fetch_ctrl u_ctrl (
        .clk, .rst, .start_of_screen, .start_of_line, .cfg,
        .bus_rddata, .bus_ack, .bus_addr, .bus_strobe,
        .map_addr, .tile_addr, .line_idx, .tile_col, .cur_entry, .word_sel,
        .render_start, .rword, .render_busy, .line_done
    );

    pixel_renderer u_pix (
        .clk, .rst, .start_of_line, .cfg, .render_start, .rword, .render_busy,
        .linebuf_wridx, .linebuf_wrdata, .linebuf_wren, .line_done
    );

endmodule

//--- pixel_renderer.sv
`include "layer_consts.svh"

module pixel_renderer import layer_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         start_of_line,
    input  layer_cfg_t   cfg,
    input  logic         render_start,
    input  render_word_t rword,
    output logic         render_busy,
    output logic [9:0]   linebuf_wridx,
    output logic [7:0]   linebuf_wrdata,
    output logic         linebuf_wren,
    output logic         line_done
);

    render_word_t word_r;
    render_word_t cur_word;
    logic [2:0]   xcnt_r;
    logic [2:0]   xcnt_next;
    logic [2:0]   last_pix;
    logic         busy_r;
    logic         busy_next;
    logic [9:0]   idx_r;
    logic [9:0]   idx_next;
    logic         wren_next;
    logic [1:0]   byte_sel;
    logic [7:0]   byte_val;
    logic [3:0]   nib;
    logic [7:0]   color;

    assign line_done   = (idx_r == 10'(`LAYER_LINE_PIXELS));
    assign render_busy = busy_next;

    // First pixel comes straight from rword
    assign cur_word = render_start ? rword : word_r;
    assign last_pix = cfg.depth8 ? 3'd3 : 3'd7;

    ////////////////////////////////////////////////////////////////////////////
    // Pixel select, MSB first within each byte
    ////////////////////////////////////////////////////////////////////////////

    assign byte_sel = cfg.depth8 ? xcnt_r[1:0] : xcnt_r[2:1];
    assign byte_val = cur_word.data[{byte_sel, 3'b000} +: 8];
    assign nib      = xcnt_r[0] ? byte_val[3:0] : byte_val[7:4];

    always_comb begin
        if (cfg.depth8) begin
            color = byte_val;
        end else if (nib == 4'd0) begin
            color = 8'h00;                      // Transparent keeps index 0
        end else begin
            color = {cur_word.palette, nib};
        end
    end

    always_comb begin
        xcnt_next = xcnt_r;
        busy_next = busy_r;
        idx_next  = idx_r;
        wren_next = 1'b0;

        if (!line_done && (busy_r || render_start)) begin
            wren_next = 1'b1;
            idx_next  = idx_r + 10'd1;
            if (render_start) begin
                xcnt_next = 3'd1;
                busy_next = 1'b1;
            end else if (xcnt_r == last_pix) begin
                xcnt_next = 3'd0;
                busy_next = 1'b0;               // Frees the slot for the next word
            end else begin
                xcnt_next = xcnt_r + 3'd1;
            end
        end

        if (start_of_line) begin
            xcnt_next = 3'd0;
            busy_next = 1'b0;
            idx_next  = 10'd0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            xcnt_r       <= 3'd0;
            busy_r       <= 1'b0;
            idx_r        <= 10'd0;
            linebuf_wren <= 1'b0;
        end else begin
            xcnt_r       <= xcnt_next;
            busy_r       <= busy_next;
            idx_r        <= idx_next;
            linebuf_wren <= wren_next;
        end
    end

    always_ff @(posedge clk) begin
        if (render_start) begin
            word_r <= rword;
        end
        linebuf_wridx  <= idx_r;
        linebuf_wrdata <= color;
    end

endmodule

//--- line_fetch_ctrl.sv
`include "layer_consts.svh"

module line_fetch_ctrl import layer_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         start_of_screen,
    input  logic         start_of_line,
    input  layer_cfg_t   cfg,
    input  logic [31:0]  bus_rddata,
    input  logic         bus_ack,
    output logic [17:0]  bus_addr,
    output logic         bus_strobe,
    input  logic [17:0]  map_addr,
    input  logic [17:0]  tile_addr,
    output logic [11:0]  line_idx,
    output logic [7:0]   tile_col,
    output map_entry_t   cur_entry,
    output logic         word_sel,
    output logic         render_start,
    output render_word_t rword,
    input  logic         render_busy,
    input  logic         line_done
);

    typedef enum logic [2:0] {
        ST_IDLE, ST_MAP_FETCH, ST_MAP_WAIT, ST_TILE_FETCH, ST_TILE_WAIT, ST_HANDOFF
    } state_t;

    state_t      state;
    logic        strobe_r;
    logic [11:0] line_next;
    logic [31:0] map_word_r;
    logic [31:0] tile_data_r;
    logic        last_word;
    logic        line_sent;
    logic        send;

    assign bus_strobe = strobe_r && !bus_ack;
    assign cur_entry  = tile_col[0] ? map_entry_t'(map_word_r[31:16])
                                    : map_entry_t'(map_word_r[15:0]);

    assign last_word = !cfg.depth8 || word_sel;                  // 8bpp needs two words
    assign line_sent = (tile_col == 8'(`LAYER_LINE_PIXELS / 8));  // Every tile handed off
    assign send      = (state == ST_HANDOFF) && !line_done && !render_busy && !line_sent;

    ////////////////////////////////////////////////////////////////////////////
    // Fetch sequencing
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= ST_IDLE;
            strobe_r     <= 1'b0;
            bus_addr     <= 18'd0;
            line_idx     <= 12'd0;
            line_next    <= 12'd0;
            tile_col     <= 8'd0;
            word_sel     <= 1'b0;
            render_start <= 1'b0;
        end else begin
            render_start <= 1'b0;

            case (state)
                ST_MAP_FETCH: begin
                    bus_addr <= map_addr;
                    strobe_r <= 1'b1;
                    state    <= ST_MAP_WAIT;
                end
                ST_MAP_WAIT: if (bus_ack) begin
                    strobe_r <= 1'b0;
                    state    <= ST_TILE_FETCH;
                end
                ST_TILE_FETCH: begin
                    bus_addr <= tile_addr;
                    strobe_r <= 1'b1;
                    state    <= ST_TILE_WAIT;
                end
                ST_TILE_WAIT: if (bus_ack) begin
                    strobe_r <= 1'b0;
                    state    <= ST_HANDOFF;
                end
                ST_HANDOFF: begin
                    if (line_done) begin
                        state <= ST_IDLE;
                    end else if (send) begin
                        render_start <= 1'b1;
                        if (last_word) begin
                            word_sel <= 1'b0;
                            tile_col <= tile_col + 8'd1;
                            // Last tile stays here until the line is written
                            if (tile_col != 8'(`LAYER_LINE_PIXELS / 8 - 1)) begin
                                state <= tile_col[0] ? ST_MAP_FETCH : ST_TILE_FETCH;
                            end
                        end else begin
                            word_sel <= 1'b1;
                            state    <= ST_TILE_FETCH;
                        end
                    end
                end
                default: begin
                end
            endcase

            if (start_of_line) begin
                state     <= ST_MAP_FETCH;
                strobe_r  <= 1'b0;
                tile_col  <= 8'd0;
                word_sel  <= 1'b0;
                line_idx  <= line_next;
                line_next <= line_next + 12'd1;
            end

            if (start_of_screen) begin
                line_idx  <= 12'd0;
                line_next <= start_of_line ? 12'd1 : 12'd0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Data capture
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (state == ST_MAP_WAIT && bus_ack) begin
            map_word_r <= bus_rddata;
        end
        if (state == ST_TILE_WAIT && bus_ack) begin
            tile_data_r <= bus_rddata;
        end
        if (send) begin
            rword.data    <= tile_data_r;
            rword.palette <= cur_entry.palette;  // Entry still selected by tile_col
        end
    end

endmodule

//--- fetch_addr_gen.sv
`include "layer_consts.svh"

module fetch_addr_gen import layer_pkg::*; (
    input  layer_cfg_t  cfg,
    input  logic [11:0] line_idx,
    input  logic [7:0]  tile_col,
    input  map_entry_t  cur_entry,
    input  logic        word_sel,
    output logic [17:0] map_addr,
    output logic [17:0] tile_addr
);

    logic [9:0]  map_idx;
    logic [15:0] map_word;
    logic [15:0] tile_ofs;
    logic [15:0] tile_word;

    // Tile row then tile column, wraps at 32 in both directions
    assign map_idx = {line_idx[`LAYER_MAP_DIM_LOG2+2:3], tile_col[`LAYER_MAP_DIM_LOG2-1:0]};

    // Two entries per map word
    assign map_word = cfg.map_base + {7'b0, map_idx[9:1]};
    assign map_addr = {map_word, 2'b00};

    // 4bpp tiles are 8 words, 8bpp tiles are 16 words
    always_comb begin
        if (cfg.depth8) begin
            tile_ofs = {2'b0, cur_entry.tile_idx, line_idx[2:0], word_sel};
        end else begin
            tile_ofs = {3'b0, cur_entry.tile_idx, line_idx[2:0]};
        end
    end

    assign tile_word = cfg.tile_base + tile_ofs;
    assign tile_addr = {tile_word, 2'b00};  // Byte address

endmodule

//--- layer_regs.sv
`include "layer_consts.svh"

module layer_regs import layer_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic [3:0] regs_addr,
    input  logic [7:0] regs_wrdata,
    input  logic       regs_write,
    output logic [7:0] regs_rddata,
    output layer_cfg_t cfg
);

    // Byte writes
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cfg.depth8    <= 1'b0;
            cfg.map_base  <= `LAYER_MAP_RESET;
            cfg.tile_base <= `LAYER_TILE_RESET;
        end else if (regs_write) begin
            case (regs_addr)
                `LAYER_REG_CTRL:    cfg.depth8          <= regs_wrdata[0];
                `LAYER_REG_MAP_LO:  cfg.map_base[7:0]   <= regs_wrdata;
                `LAYER_REG_MAP_HI:  cfg.map_base[15:8]  <= regs_wrdata;
                `LAYER_REG_TILE_LO: cfg.tile_base[7:0]  <= regs_wrdata;
                `LAYER_REG_TILE_HI: cfg.tile_base[15:8] <= regs_wrdata;
                default: begin
                end
            endcase
        end
    end

    // Readback, same byte layout as the writes
    always_comb begin
        case (regs_addr)
            `LAYER_REG_CTRL:    regs_rddata = {7'b0, cfg.depth8};
            `LAYER_REG_MAP_LO:  regs_rddata = cfg.map_base[7:0];
            `LAYER_REG_MAP_HI:  regs_rddata = cfg.map_base[15:8];
            `LAYER_REG_TILE_LO: regs_rddata = cfg.tile_base[7:0];
            `LAYER_REG_TILE_HI: regs_rddata = cfg.tile_base[15:8];
            default:            regs_rddata = 8'h00;  // Unused addresses
        endcase
    end

endmodule

//--- layer_pkg.sv
package layer_pkg;

    ////////////////////////////////////////////////////////////////////////
    // Register contents
    ////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic        depth8;     // 0 is 4bpp, 1 is 8bpp
        logic [15:0] map_base;   // Word address of the map
        logic [15:0] tile_base;  // Word address of the tile set
    } layer_cfg_t;

    ////////////////////////////////////////////////////////////////////////
    // Memory formats
    ////////////////////////////////////////////////////////////////////////

    // One 16-bit map entry, two per 32-bit map word
    typedef struct packed {
        logic [3:0] palette;   // Upper nibble for nonzero 4bpp pixels
        logic [1:0] rsvd;
        logic [9:0] tile_idx;
    } map_entry_t;

    // Tile word on its way to the pixel stage
    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  palette;
    } render_word_t;

endpackage

//--- layer_consts.svh
`ifndef LAYER_CONSTS_SVH
`define LAYER_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// Register map
////////////////////////////////////////////////////////////////////////////

`define LAYER_REG_CTRL    4'd0  // Bit 0 selects 8bpp
`define LAYER_REG_MAP_LO  4'd2
`define LAYER_REG_MAP_HI  4'd3
`define LAYER_REG_TILE_LO 4'd4
`define LAYER_REG_TILE_HI 4'd5

// Base addresses after reset, in 32-bit words
`define LAYER_MAP_RESET   16'h0000
`define LAYER_TILE_RESET  16'h8000

////////////////////////////////////////////////////////////////////////////
// Geometry
////////////////////////////////////////////////////////////////////////////

`define LAYER_LINE_PIXELS  640  // Visible pixels per line
`define LAYER_MAP_DIM_LOG2 5    // 32 x 32 map entries

`endif
